// ==== chip_io.f ====
logic/chip_io_pkg.sv
logic/pad_attr_ctrl.sv
logic/pad_ring.sv
logic/jtag_overlay_mux.sv
logic/chip_io_top.sv
tb/chip_io_tb.sv

// ==== logic/chip_io_pkg.sv ====
////////////////////////////////////////////////////////////
// Pad count and JTAG pin map are fixed, no per-build override
// Attribute bits apply to every pad the same way
////////////////////////////////////////////////////////////

package chip_io_pkg;

  ////////////////////////////////////////////////////////////
  // Pad ring size and attributes
  ////////////////////////////////////////////////////////////

  localparam int NumPads = 8;
  localparam int AttrDw  = 3;

  // Attribute bit positions
  localparam int AttrInvIdx   = 0;  // Invert out and in
  localparam int AttrOdIdx    = 1;  // Open drain, drive low only
  localparam int AttrInDisIdx = 2;  // Force input to 0

  typedef logic [AttrDw-1:0]           pad_attr_t;
  typedef logic [$clog2(NumPads)-1:0]  pad_idx_t;

  ////////////////////////////////////////////////////////////
  // JTAG pad map
  ////////////////////////////////////////////////////////////

  localparam int JtagEnIdx = 7;  // Strap, active high

  localparam int TckIdx = 0;
  localparam int TmsIdx = 1;
  localparam int TdiIdx = 2;
  localparam int TdoIdx = 3;

  // Core-side input values on the taken-over pads while JTAG owns them.
  // TMS idles high, everything else reads 0
  localparam logic [NumPads-1:0] TieOffValues = NumPads'(1 << TmsIdx);

endpackage : chip_io_pkg

// ==== logic/chip_io_top.sv ====
////////////////////////////////////////////////////////////
// Pad I/O subsystem, the core side is brought out as ports
// JTAG takes effect 3 clocks after the strap pad rises
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module chip_io_top (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // Attribute configuration
  input  logic                            cfg_valid_i,
  output logic                            cfg_ready_o,
  input  chip_io_pkg::pad_idx_t           cfg_idx_i,
  input  chip_io_pkg::pad_attr_t          cfg_attr_i,
  output logic                            cfg_rsp_valid_o,
  input  logic                            cfg_rsp_ready_i,
  output chip_io_pkg::pad_attr_t          cfg_rsp_attr_o,
  // Core side
  input  logic [chip_io_pkg::NumPads-1:0] core_out_i,
  input  logic [chip_io_pkg::NumPads-1:0] core_oe_i,
  output logic [chip_io_pkg::NumPads-1:0] core_in_o,
  // Pad side
  output logic [chip_io_pkg::NumPads-1:0] pad_out_o,
  output logic [chip_io_pkg::NumPads-1:0] pad_oe_o,
  input  logic [chip_io_pkg::NumPads-1:0] pad_in_i,
  // JTAG
  output logic                            jtag_tck_o,
  output logic                            jtag_tms_o,
  output logic                            jtag_tdi_o,
  input  logic                            jtag_tdo_i
);

  logic [chip_io_pkg::NumPads*chip_io_pkg::AttrDw-1:0] pad_attr;
  logic                                                jtag_en;
  logic [chip_io_pkg::NumPads-1:0]                     ring_out;
  logic [chip_io_pkg::NumPads-1:0]                     ring_oe;
  logic [chip_io_pkg::NumPads-1:0]                     ring_in;  // Synced, attrs applied

  pad_attr_ctrl u_pad_attr_ctrl (
    .clk_i           ( clk_i                         ),
    .reset_i         ( reset_i                       ),
    .cfg_valid_i     ( cfg_valid_i                   ),
    .cfg_ready_o     ( cfg_ready_o                   ),
    .cfg_idx_i       ( cfg_idx_i                     ),
    .cfg_attr_i      ( cfg_attr_i                    ),
    .cfg_rsp_valid_o ( cfg_rsp_valid_o               ),
    .cfg_rsp_ready_i ( cfg_rsp_ready_i               ),
    .cfg_rsp_attr_o  ( cfg_rsp_attr_o                ),
    .strap_i         ( ring_in[chip_io_pkg::JtagEnIdx] ),
    .attr_o          ( pad_attr                      ),
    .jtag_en_o       ( jtag_en                       )
  );

  pad_ring u_pad_ring (
    .clk_i      ( clk_i     ),
    .reset_i    ( reset_i   ),
    .attr_i     ( pad_attr  ),
    .core_out_i ( ring_out  ),
    .core_oe_i  ( ring_oe   ),
    .core_in_o  ( ring_in   ),
    .pad_out_o  ( pad_out_o ),
    .pad_oe_o   ( pad_oe_o  ),
    .pad_in_i   ( pad_in_i  )
  );

  jtag_overlay_mux u_jtag_overlay_mux (
    .jtag_en_i  ( jtag_en    ),
    .core_out_i ( core_out_i ),
    .core_oe_i  ( core_oe_i  ),
    .core_in_o  ( core_in_o  ),
    .ring_out_o ( ring_out   ),
    .ring_oe_o  ( ring_oe    ),
    .ring_in_i  ( ring_in    ),
    .jtag_tck_o ( jtag_tck_o ),
    .jtag_tms_o ( jtag_tms_o ),
    .jtag_tdi_o ( jtag_tdi_o ),
    .jtag_tdo_i ( jtag_tdo_i )
  );

endmodule : chip_io_top

// ==== logic/jtag_overlay_mux.sv ====
////////////////////////////////////////////////////////////
// Takes over TCK/TMS/TDI/TDO pads while jtag_en_i is high
// Strap pad and the rest always pass through
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jtag_overlay_mux (
  input  logic                              jtag_en_i,
  // Core side
  input  logic [chip_io_pkg::NumPads-1:0]   core_out_i,
  input  logic [chip_io_pkg::NumPads-1:0]   core_oe_i,
  output logic [chip_io_pkg::NumPads-1:0]   core_in_o,
  // Ring side
  output logic [chip_io_pkg::NumPads-1:0]   ring_out_o,
  output logic [chip_io_pkg::NumPads-1:0]   ring_oe_o,
  input  logic [chip_io_pkg::NumPads-1:0]   ring_in_i,
  // JTAG port
  output logic                              jtag_tck_o,
  output logic                              jtag_tms_o,
  output logic                              jtag_tdi_o,
  input  logic                              jtag_tdo_i
);

  always_comb begin
    // Default is plain pass-through
    ring_out_o = core_out_i;
    ring_oe_o  = core_oe_i;
    core_in_o  = ring_in_i;
    jtag_tck_o = 1'b0;
    jtag_tms_o = 1'b0;
    jtag_tdi_o = 1'b0;

    if (jtag_en_i) begin
      // JTAG inputs, pads stay undriven
      jtag_tck_o = ring_in_i[chip_io_pkg::TckIdx];
      jtag_tms_o = ring_in_i[chip_io_pkg::TmsIdx];
      jtag_tdi_o = ring_in_i[chip_io_pkg::TdiIdx];
      ring_out_o[chip_io_pkg::TckIdx] = 1'b0;
      ring_out_o[chip_io_pkg::TmsIdx] = 1'b0;
      ring_out_o[chip_io_pkg::TdiIdx] = 1'b0;
      ring_oe_o[chip_io_pkg::TckIdx]  = 1'b0;
      ring_oe_o[chip_io_pkg::TmsIdx]  = 1'b0;
      ring_oe_o[chip_io_pkg::TdiIdx]  = 1'b0;

      // TDO always driven
      ring_out_o[chip_io_pkg::TdoIdx] = jtag_tdo_i;
      ring_oe_o[chip_io_pkg::TdoIdx]  = 1'b1;

      // Core sees idle values on the borrowed pads
      core_in_o[chip_io_pkg::TckIdx] = chip_io_pkg::TieOffValues[chip_io_pkg::TckIdx];
      core_in_o[chip_io_pkg::TmsIdx] = chip_io_pkg::TieOffValues[chip_io_pkg::TmsIdx];
      core_in_o[chip_io_pkg::TdiIdx] = chip_io_pkg::TieOffValues[chip_io_pkg::TdiIdx];
      core_in_o[chip_io_pkg::TdoIdx] = chip_io_pkg::TieOffValues[chip_io_pkg::TdoIdx];
    end
  end

endmodule : jtag_overlay_mux

// ==== logic/pad_attr_ctrl.sv ====
////////////////////////////////////////////////////////////
// One response outstanding at most, new writes stall on it
// strap_i must already be synchronized to clk_i
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pad_attr_ctrl (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  // Configuration request
  input  logic                                           cfg_valid_i,
  output logic                                           cfg_ready_o,
  input  chip_io_pkg::pad_idx_t                          cfg_idx_i,
  input  chip_io_pkg::pad_attr_t                         cfg_attr_i,
  // Configuration response, old attribute value
  output logic                                           cfg_rsp_valid_o,
  input  logic                                           cfg_rsp_ready_i,
  output chip_io_pkg::pad_attr_t                         cfg_rsp_attr_o,
  // Strap and outputs to the ring and mux
  input  logic                                           strap_i,
  output logic [chip_io_pkg::NumPads*chip_io_pkg::AttrDw-1:0] attr_o,
  output logic                                           jtag_en_o
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  chip_io_pkg::pad_attr_t [chip_io_pkg::NumPads-1:0] attr_q;

  logic                   cfg_fire;
  logic                   rsp_valid_q;
  chip_io_pkg::pad_attr_t rsp_attr_q;
  logic                   jtag_en_q;

  // Request accepted only when no response is pending
  assign cfg_ready_o = ~rsp_valid_q;
  assign cfg_fire    = cfg_valid_i & cfg_ready_o;

  ////////////////////////////////////////////////////////////
  // Attribute registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      attr_q <= '0;  // All pads pass straight through
    end else if (cfg_fire) begin
      attr_q[cfg_idx_i] <= cfg_attr_i;
    end
  end

  assign attr_o = attr_q;  // Pad 0 in the low bits

  ////////////////////////////////////////////////////////////
  // Response channel
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (cfg_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (cfg_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;  // Response taken
    end
  end

  // Old value, read before the write lands
  always_ff @(posedge clk_i) begin
    if (cfg_fire) begin
      rsp_attr_q <= attr_q[cfg_idx_i];
    end
  end

  assign cfg_rsp_valid_o = rsp_valid_q;
  assign cfg_rsp_attr_o  = rsp_attr_q;

  ////////////////////////////////////////////////////////////
  // JTAG enable
  ////////////////////////////////////////////////////////////

  // Third stage after the two-flop pad sync
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      jtag_en_q <= 1'b0;
    end else begin
      jtag_en_q <= strap_i;
    end
  end

  assign jtag_en_o = jtag_en_q;

endmodule : pad_attr_ctrl

// ==== logic/pad_ring.sv ====
////////////////////////////////////////////////////////////
// Pads split into out, oe and in, no inout modelling
// Output path is combinational, input path has a 2-flop sync
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pad_ring (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  input  logic [chip_io_pkg::NumPads*chip_io_pkg::AttrDw-1:0] attr_i,
  // Core side
  input  logic [chip_io_pkg::NumPads-1:0]                     core_out_i,
  input  logic [chip_io_pkg::NumPads-1:0]                     core_oe_i,
  output logic [chip_io_pkg::NumPads-1:0]                     core_in_o,
  // Pad side
  output logic [chip_io_pkg::NumPads-1:0]                     pad_out_o,
  output logic [chip_io_pkg::NumPads-1:0]                     pad_oe_o,
  input  logic [chip_io_pkg::NumPads-1:0]                     pad_in_i
);

  logic [chip_io_pkg::NumPads-1:0] in_sync_q1;
  logic [chip_io_pkg::NumPads-1:0] in_sync_q2;

  ////////////////////////////////////////////////////////////
  // Output drivers
  ////////////////////////////////////////////////////////////

  always_comb begin
    chip_io_pkg::pad_attr_t attr;
    logic                   out_inv;
    for (int i = 0; i < chip_io_pkg::NumPads; i++) begin
      attr    = attr_i[i*chip_io_pkg::AttrDw +: chip_io_pkg::AttrDw];
      out_inv = core_out_i[i] ^ attr[chip_io_pkg::AttrInvIdx];
      if (attr[chip_io_pkg::AttrOdIdx]) begin
        // Pull low on a 0, float on a 1
        pad_out_o[i] = 1'b0;
        pad_oe_o[i]  = core_oe_i[i] & ~out_inv;
      end else begin
        pad_out_o[i] = out_inv;
        pad_oe_o[i]  = core_oe_i[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Input synchronizer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_sync_q1 <= '0;
      in_sync_q2 <= '0;
    end else begin
      in_sync_q1 <= pad_in_i;
      in_sync_q2 <= in_sync_q1;
    end
  end

  // Attributes applied after the sync, so a change takes effect at once
  always_comb begin
    for (int i = 0; i < chip_io_pkg::NumPads; i++) begin
      core_in_o[i] = (in_sync_q2[i] ^ attr_i[i*chip_io_pkg::AttrDw + chip_io_pkg::AttrInvIdx])
                     & ~attr_i[i*chip_io_pkg::AttrDw + chip_io_pkg::AttrInDisIdx];
    end
  end

endmodule : pad_ring

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the chip_io testbench with Verilator

rm -f build.log sim.log
verilator --binary --timing --timescale 1ns/1ps -f chip_io.f \
  --top-module chip_io_tb -o chip_io_sim > build.log 2>&1 &&
  ./obj_dir/chip_io_sim > sim.log 2>&1
cat build.log
[ -f sim.log ] && cat sim.log

grep -qx "all tests passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// ==== tb/chip_io_tb.sv ====
////////////////////////////////////////////////////////////
// Random writes go to pads 0 to 6, the strap pad keeps attribute 0
// Outputs are compared every cycle, 4 ns after the rising edge
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module chip_io_tb;

  localparam int TimeoutCycles = 2000;  // Tests take about 250 cycles

  logic                         clk_i = 1'b0;
  logic                         reset_i;
  logic                         cfg_valid_i;
  logic                         cfg_ready_o;
  chip_io_pkg::pad_idx_t        cfg_idx_i;
  chip_io_pkg::pad_attr_t       cfg_attr_i;
  logic                         cfg_rsp_valid_o;
  logic                         cfg_rsp_ready_i;
  chip_io_pkg::pad_attr_t       cfg_rsp_attr_o;
  logic [7:0]                   core_out_i, core_oe_i, core_in_o;
  logic [7:0]                   pad_out_o, pad_oe_o, pad_in_i;
  logic                         jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_tdo_i;

  chip_io_pkg::pad_attr_t attr_m [chip_io_pkg::NumPads];  // Attribute model
  logic       strap_val;
  logic       checking = 1'b0;
  int         err_cnt = 0;
  int         chk_cnt = 0;
  int         cycle_cnt = 0;
  logic [2:0][7:0] pad_hist = '0;  // Pad input seen at the last three checks
  logic       jen_exp;
  logic [15:0] pads_exp;
  logic [7:0] ring_exp;

  chip_io_top UUT (.*);

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Synchronized pad value after invert and input-disable
  function automatic logic [7:0] ref_ring_in(logic [7:0] pad);
    logic [7:0] r;
    for (int i = 0; i < chip_io_pkg::NumPads; i++) begin
      r[i] = (pad[i] ^ attr_m[i][chip_io_pkg::AttrInvIdx]) & ~attr_m[i][chip_io_pkg::AttrInDisIdx];
    end
    return r;
  endfunction

  function automatic logic [7:0] ref_core_in(logic [7:0] pad, logic jen);
    logic [7:0] r;
    r = ref_ring_in(pad);
    if (jen) begin
      r[chip_io_pkg::TckIdx] = chip_io_pkg::TieOffValues[chip_io_pkg::TckIdx];
      r[chip_io_pkg::TmsIdx] = chip_io_pkg::TieOffValues[chip_io_pkg::TmsIdx];
      r[chip_io_pkg::TdiIdx] = chip_io_pkg::TieOffValues[chip_io_pkg::TdiIdx];
      r[chip_io_pkg::TdoIdx] = chip_io_pkg::TieOffValues[chip_io_pkg::TdoIdx];
    end
    return r;
  endfunction

  // Returns {oe, out}
  function automatic logic [15:0] ref_pad_out(logic [7:0] c_out, logic [7:0] c_oe, logic jen,
                                               logic tdo);
    logic [7:0] m_out, m_oe, p_out, p_oe;
    logic       v;
    m_out = c_out;
    m_oe  = c_oe;
    if (jen) begin
      m_out[2:0] = 3'b000;  // TCK, TMS, TDI are inputs
      m_oe[2:0]  = 3'b000;
      m_out[chip_io_pkg::TdoIdx] = tdo;
      m_oe[chip_io_pkg::TdoIdx]  = 1'b1;
    end
    for (int i = 0; i < chip_io_pkg::NumPads; i++) begin
      v = m_out[i] ^ attr_m[i][chip_io_pkg::AttrInvIdx];
      p_out[i] = attr_m[i][chip_io_pkg::AttrOdIdx] ? 1'b0 : v;
      p_oe[i]  = attr_m[i][chip_io_pkg::AttrOdIdx] ? (m_oe[i] & ~v) : m_oe[i];
    end
    return {p_oe, p_out};
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_pads(string name, logic [7:0] got, logic [7:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error: %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic check_attr(string name, chip_io_pkg::pad_attr_t got,
                            chip_io_pkg::pad_attr_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error: %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic check_jtag(string name, logic got, logic exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error: %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error: %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
    end
  endtask

  // Strap reaches jtag_en 3 edges after the pad, core_in lags 2 edges
  always begin
    @(posedge clk_i);
    #4;
    pad_hist = {pad_hist[1:0], pad_in_i};
    if (checking) begin
      jen_exp  = pad_hist[2][chip_io_pkg::JtagEnIdx];
      pads_exp = ref_pad_out(core_out_i, core_oe_i, jen_exp, jtag_tdo_i);
      ring_exp = ref_ring_in(pad_hist[1]);
      check_pads("pad_out_o", pad_out_o, pads_exp[7:0]);
      check_pads("pad_oe_o", pad_oe_o, pads_exp[15:8]);
      check_pads("core_in_o", core_in_o, ref_core_in(pad_hist[1], jen_exp));
      check_jtag("jtag_tck_o", jtag_tck_o, jen_exp & ring_exp[chip_io_pkg::TckIdx]);
      check_jtag("jtag_tms_o", jtag_tms_o, jen_exp & ring_exp[chip_io_pkg::TmsIdx]);
      check_jtag("jtag_tdi_o", jtag_tdi_o, jen_exp & ring_exp[chip_io_pkg::TdiIdx]);
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt == TimeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks, each starts and ends on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic drive_vector();
    @(negedge clk_i);
    core_out_i = 8'($urandom);
    core_oe_i  = 8'($urandom);
    pad_in_i   = {strap_val, 7'($urandom)};
    jtag_tdo_i = 1'($urandom);
  endtask

  task automatic send_req(chip_io_pkg::pad_idx_t idx, chip_io_pkg::pad_attr_t attr,
                          output chip_io_pkg::pad_attr_t prev);
    cfg_valid_i = 1'b1;
    cfg_idx_i   = idx;
    cfg_attr_i  = attr;
    while (!cfg_ready_o) @(negedge clk_i);
    @(posedge clk_i);  // Transfer edge
    prev        = attr_m[idx];
    attr_m[idx] = attr;
    @(negedge clk_i);
    cfg_valid_i = 1'b0;
  endtask

  // Holds the response for hold cycles before taking it
  task automatic take_rsp(chip_io_pkg::pad_attr_t exp, int hold);
    for (int i = 0; i <= hold; i++) begin
      if (i > 0) @(negedge clk_i);
      check_flag("cfg_rsp_valid_o", cfg_rsp_valid_o, 1'b1);
      check_flag("cfg_ready_o", cfg_ready_o, 1'b0);
      check_attr("cfg_rsp_attr_o", cfg_rsp_attr_o, exp);
    end
    cfg_rsp_ready_i = 1'b1;
    @(negedge clk_i);
    cfg_rsp_ready_i = 1'b0;
    check_flag("cfg_rsp_valid_o", cfg_rsp_valid_o, 1'b0);
    check_flag("cfg_ready_o", cfg_ready_o, 1'b1);
  endtask

  task automatic report_test(string name, int start_errs);
    if (err_cnt == start_errs) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, err_cnt - start_errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int                     start_errs;
    chip_io_pkg::pad_attr_t prev;
    chip_io_pkg::pad_attr_t attr_a;
    void'($urandom(32'hfae6));
    reset_i = 1'b1;
    cfg_valid_i = 1'b0;
    cfg_idx_i = '0;
    cfg_attr_i = '0;
    cfg_rsp_ready_i = 1'b0;
    core_out_i = '0;
    core_oe_i = '0;
    pad_in_i = '0;
    jtag_tdo_i = 1'b0;
    strap_val = 1'b0;
    for (int i = 0; i < chip_io_pkg::NumPads; i++) attr_m[i] = '0;
    repeat (5) @(negedge clk_i);
    reset_i  = 1'b0;
    checking = 1'b1;

    start_errs = err_cnt;
    check_flag("cfg_ready_o", cfg_ready_o, 1'b1);
    check_flag("cfg_rsp_valid_o", cfg_rsp_valid_o, 1'b0);
    repeat (10) drive_vector();
    pad_in_i = 8'h5a;
    repeat (2) @(negedge clk_i);
    check_pads("core_in_o", core_in_o, 8'h5a);  // Two sync stages
    report_test("1 reset and pass-through", start_errs);

    start_errs = err_cnt;
    repeat (6) begin
      send_req(chip_io_pkg::pad_idx_t'($urandom % 7), chip_io_pkg::pad_attr_t'($urandom), prev);
      take_rsp(prev, 0);
      repeat (20) drive_vector();
    end
    report_test("2 random attributes", start_errs);

    start_errs = err_cnt;
    for (int i = 0; i < chip_io_pkg::JtagEnIdx; i++) begin
      send_req(chip_io_pkg::pad_idx_t'(i), chip_io_pkg::pad_attr_t'($urandom), prev);
      take_rsp(prev, 1);
    end
    report_test("3 write responses", start_errs);

    // Second request to the same pad stalls behind the first response
    start_errs = err_cnt;
    attr_a = chip_io_pkg::pad_attr_t'($urandom);
    send_req(chip_io_pkg::pad_idx_t'(4), attr_a, prev);
    cfg_valid_i = 1'b1;
    cfg_idx_i   = chip_io_pkg::pad_idx_t'(4);
    cfg_attr_i  = ~attr_a;
    take_rsp(prev, 6);
    send_req(chip_io_pkg::pad_idx_t'(4), ~attr_a, prev);
    take_rsp(prev, 0);  // Old value is attr_a
    report_test("4 back-pressure", start_errs);

    start_errs = err_cnt;
    send_req(chip_io_pkg::pad_idx_t'(chip_io_pkg::TdoIdx), 3'b001, prev);  // TDO inverted
    take_rsp(prev, 0);
    strap_val = 1'b1;
    drive_vector();
    repeat (3) @(negedge clk_i);
    check_pads("core_in_o[3:0]", core_in_o & 8'h0f, chip_io_pkg::TieOffValues & 8'h0f);
    check_jtag("pad_out_o[3]", pad_out_o[chip_io_pkg::TdoIdx], ~jtag_tdo_i);
    check_jtag("pad_oe_o[3]", pad_oe_o[chip_io_pkg::TdoIdx], 1'b1);
    repeat (20) drive_vector();
    strap_val = 1'b0;
    drive_vector();
    repeat (3) @(negedge clk_i);
    check_jtag("jtag_tck_o", jtag_tck_o, 1'b0);
    repeat (20) drive_vector();
    report_test("5 JTAG overlay", start_errs);

    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : chip_io_tb
